/* dv/radio_db_core_tb.sv */
// slot controller testbench with clock, reset, stimulus, reference model, checker, watchdog
`timescale 1ns/1ps
`include "db_params.svh"

module radio_db_core_tb;
   import db_pkg::*;

   localparam int CLK_PERIOD  = 8;
   localparam int N_WR        = 40;   // random settings writes
   localparam int N_FLAG      = 24;   // run flag patterns
   localparam int N_BURST     = 15;   // back-to-back readbacks
   localparam int TEST_CYCLES = 8 + (2*N_WR + 8) + (3*N_FLAG + 6) + 7*6 + (N_BURST + 10);
   localparam int WATCHDOG_NS = TEST_CYCLES*CLK_PERIOD + 400;

   logic        radio_clk;
   logic        i_arst_n;
   logic        i_set_stb;
   set_addr_t   i_set_addr;
   set_data_t   i_set_data;
   logic        i_rb_stb;
   set_addr_t   i_rb_addr;
   logic        o_rb_valid;
   rb_data_t    o_rb_data;
   chan_flags_t i_rx_running;
   chan_flags_t i_tx_running;
   set_data_t   i_db_gpio_in;
   set_data_t   o_db_gpio_out;
   set_data_t   o_db_gpio_ddr;
   led_t        o_radio_led;
   set_data_t   i_misc_in;
   set_data_t   o_misc_out;

   // reference model state
   set_data_t  sh_idle, sh_rx, sh_tx, sh_fdx, sh_ddr, sh_misc;   // shadow registers
   atr_state_t m_state;
   set_data_t  m_gpio_out, m_ddr, m_misc;
   led_t       m_led;
   logic       m_rb_valid;
   rb_data_t   m_rb_data;
   set_data_t  m_gin_q, m_min_q;   // captured pins
   logic       m_live;             // out of reset, compare on

   int          error_count = 0;
   int          check_count = 0;
   int          test_count  = 0;
   logic [31:0] seed = 32'h7d47;

   radio_db_core u_dut (.*);

   initial begin : clock_gen
      radio_clk = 1'b0;
      forever #(CLK_PERIOD/2) radio_clk = ~radio_clk;
   end

   // ----------------------------------------
   // random source and reference functions
   // ----------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      seed = xorshift32(seed);
      return seed;
   endfunction

   function automatic atr_state_t state_of(input chan_flags_t rx, input chan_flags_t tx);
      if (|rx && |tx) return ATR_FDX;   // any channel counts
      if (|tx) return ATR_TX;
      if (|rx) return ATR_RX;
      return ATR_IDLE;
   endfunction

   function automatic set_data_t gpio_for(input atr_state_t s);
      case (s)
         ATR_RX:  return sh_rx;
         ATR_TX:  return sh_tx;
         ATR_FDX: return sh_fdx;
         default: return sh_idle;
      endcase
   endfunction

   // {rx port only in fdx, txrx tx in tx or fdx, txrx rx only in rx}
   function automatic led_t led_for(input atr_state_t s);
      return {s == ATR_FDX, (s == ATR_TX) || (s == ATR_FDX), s == ATR_RX};
   endfunction

   function automatic rb_data_t rb_word(input set_addr_t a, input set_data_t gin,
                                        input set_data_t min, input set_data_t gout);
      case (a)
         set_addr_t'(`DB_RB_BASE + `DB_RB_INPUTS):  return {min, gin};
         set_addr_t'(`DB_RB_BASE + `DB_RB_OUTPUTS): return {sh_ddr, gout};
         set_addr_t'(`DB_RB_BASE + `DB_RB_ATR_LO):  return {sh_rx, sh_idle};
         set_addr_t'(`DB_RB_BASE + `DB_RB_ATR_HI):  return {sh_fdx, sh_tx};
         default:                                   return '0;
      endcase
   endfunction

   // model steps on the rising edge, inputs are stable there
   always @(posedge radio_clk or negedge i_arst_n) begin : model_step
      if (!i_arst_n) begin
         {sh_idle, sh_rx, sh_tx, sh_fdx, sh_ddr, sh_misc} = '0;
         m_state    = ATR_IDLE;
         {m_gpio_out, m_ddr, m_misc, m_led} = '0;
         m_rb_valid = 1'b0;
         m_rb_data  = '0;
         m_live     = 1'b0;
      end else begin
         m_rb_valid = i_rb_stb;   // old pins and registers go into the word
         if (i_rb_stb) m_rb_data = rb_word(i_rb_addr, m_gin_q, m_min_q, m_gpio_out);
         m_gpio_out = gpio_for(m_state);
         m_ddr      = sh_ddr;
         m_misc     = sh_misc;
         m_led      = led_for(m_state);
         m_state    = state_of(i_rx_running, i_tx_running);
         if (i_set_stb) begin
            case (int'(i_set_addr) - `DB_SR_BASE)
               `DB_SR_ATR_IDLE: sh_idle = i_set_data;
               `DB_SR_ATR_RX:   sh_rx   = i_set_data;
               `DB_SR_ATR_TX:   sh_tx   = i_set_data;
               `DB_SR_ATR_FDX:  sh_fdx  = i_set_data;
               `DB_SR_GPIO_DDR: sh_ddr  = i_set_data;
               `DB_SR_MISC_OUT: sh_misc = i_set_data;
               default: ;   // not a slot register
            endcase
         end
         m_live = 1'b1;
      end
      m_gin_q = i_db_gpio_in;
      m_min_q = i_misc_in;
   end

   task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                  input logic [63:0] act_v);
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
      error_count++;
   endtask

   // ----------------------------------------
   // compare, mid-cycle
   // ----------------------------------------
   always @(negedge radio_clk) begin : compare
      if (m_live) begin
         check_count++;
         if (o_db_gpio_out !== m_gpio_out)
            report_mismatch("o_db_gpio_out", 64'(m_gpio_out), 64'(o_db_gpio_out));
         if (o_db_gpio_ddr !== m_ddr)
            report_mismatch("o_db_gpio_ddr", 64'(m_ddr), 64'(o_db_gpio_ddr));
         if (o_misc_out !== m_misc)
            report_mismatch("o_misc_out", 64'(m_misc), 64'(o_misc_out));
         if (o_radio_led !== m_led)
            report_mismatch("o_radio_led", 64'(m_led), 64'(o_radio_led));
         if (o_rb_valid !== m_rb_valid)
            report_mismatch("o_rb_valid", 64'(m_rb_valid), 64'(o_rb_valid));
         if (o_rb_data !== m_rb_data)
            report_mismatch("o_rb_data", m_rb_data, o_rb_data);
      end
   end

   // ----------------------------------------
   // bus drivers
   // ----------------------------------------
   task automatic drive_write(input set_addr_t a, input set_data_t d);
      @(negedge radio_clk);
      i_set_stb  = 1'b1;
      i_set_addr = a;
      i_set_data = d;
   endtask

   task automatic bus_idle();
      @(negedge radio_clk);
      i_set_stb = 1'b0;
      i_rb_stb  = 1'b0;
   endtask

   // one strobe, then wait for valid
   task automatic read_word(input set_addr_t a);
      int waited;
      @(negedge radio_clk);
      i_rb_stb  = 1'b1;
      i_rb_addr = a;
      @(negedge radio_clk);
      i_rb_stb = 1'b0;
      waited   = 1;
      while (!o_rb_valid && waited < 4) begin
         @(negedge radio_clk);
         waited++;
      end
      if (!o_rb_valid) begin
         $display("readback of address %0d got no valid within %0d cycles", a, waited);
         error_count++;
      end else if (waited != 1) begin
         $display("readback of address %0d answered after %0d cycles, not 1", a, waited);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      @(posedge radio_clk);   // last compare done by now
      test_count++;
      if (error_count == errs_before) $display("test %0d %s: passed", test_count, name);
      else $display("test %0d %s: failed, %0d errors", test_count, name,
                    error_count - errs_before);
   endtask

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic check_reset_outputs();
      int errs;
      errs = error_count;
      repeat (4) @(negedge radio_clk);   // still in reset here
      if (o_db_gpio_out !== '0) report_mismatch("o_db_gpio_out", 64'd0, 64'(o_db_gpio_out));
      if (o_db_gpio_ddr !== '0) report_mismatch("o_db_gpio_ddr", 64'd0, 64'(o_db_gpio_ddr));
      if (o_radio_led !== '0)   report_mismatch("o_radio_led", 64'd0, 64'(o_radio_led));
      if (o_misc_out !== '0)    report_mismatch("o_misc_out", 64'd0, 64'(o_misc_out));
      if (o_rb_valid !== 1'b0)  report_mismatch("o_rb_valid", 64'd0, 64'(o_rb_valid));
      if (o_rb_data !== '0)     report_mismatch("o_rb_data", 64'd0, o_rb_data);
      i_arst_n = 1'b1;
      repeat (2) @(negedge radio_clk);
      finish_test("reset values", errs);
   endtask

   task automatic write_random_registers();
      int          errs;
      logic [31:0] r;
      set_addr_t   a;
      errs = error_count;
      @(negedge radio_clk);
      i_rx_running = chan_flags_t'(next_rand());   // held through the test
      i_tx_running = chan_flags_t'(next_rand());
      for (int n = 0; n < N_WR; n++) begin
         r = next_rand();
         if (r[2:0] < 3'd6) a = set_addr_t'(`DB_SR_BASE + int'(r[2:0]));
         else if (r[2:0] == 3'd6) a = r[3] ? set_addr_t'(`DB_SR_BASE + 6)
                                           : set_addr_t'(`DB_SR_BASE - 1);
         else a = r[15:8];   // anywhere in the map
         drive_write(a, next_rand());
         if (r[31]) bus_idle();   // else next strobe follows directly
      end
      bus_idle();
      repeat (3) @(negedge radio_clk);
      finish_test("settings writes", errs);
   endtask

   task automatic sweep_run_flags();
      int          errs;
      logic [31:0] r;
      errs = error_count;
      for (int n = 0; n < N_FLAG; n++) begin
         r = next_rand();
         @(negedge radio_clk);
         i_rx_running = chan_flags_t'(r);
         i_tx_running = chan_flags_t'(r >> 2);
         repeat (2) @(negedge radio_clk);   // pins follow after 2 edges
      end
      repeat (3) @(negedge radio_clk);
      finish_test("ATR states and leds", errs);
   endtask

   task automatic read_every_address();
      int        errs;
      set_addr_t a;
      errs = error_count;
      @(negedge radio_clk);
      i_db_gpio_in = next_rand();
      i_misc_in    = next_rand();
      for (int n = 0; n < 7; n++) begin
         if (n < 5) a = set_addr_t'(`DB_RB_BASE + n);   // last one unmapped
         else if (n == 5) a = '0;
         else a = 8'hff;
         read_word(a);
      end
      finish_test("readback map", errs);
   endtask

   task automatic read_back_to_back();
      int errs;
      int words;
      errs  = error_count;
      words = 0;
      @(negedge radio_clk);
      i_db_gpio_in = next_rand();
      i_misc_in    = next_rand();
      i_rx_running = chan_flags_t'(next_rand());
      i_tx_running = chan_flags_t'(next_rand());
      repeat (3) @(negedge radio_clk);   // captures and pins settle
      for (int n = 0; n < N_BURST; n++) begin
         @(negedge radio_clk);
         if (o_rb_valid) words++;
         i_rb_stb  = 1'b1;
         i_rb_addr = set_addr_t'(`DB_RB_BASE + (n % 5));
      end
      @(negedge radio_clk);
      if (o_rb_valid) words++;
      i_rb_stb = 1'b0;
      if (words != N_BURST) begin
         $display("back-to-back readback gave %0d words for %0d strobes", words, N_BURST);
         error_count++;
      end
      repeat (2) @(negedge radio_clk);
      finish_test("back-to-back readback", errs);
   endtask

   initial begin : stimulus
      i_arst_n     = 1'b0;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_stb     = 1'b0;
      i_rb_addr    = '0;
      i_rx_running = '0;
      i_tx_running = '0;
      i_db_gpio_in = '0;
      i_misc_in    = '0;
      check_reset_outputs();
      write_random_registers();
      sweep_run_flags();
      read_every_address();
      read_back_to_back();
      @(posedge radio_clk);
      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog expired, tests still running after %0d ns", WATCHDOG_NS);
      $display("Errors found");
      $finish;
   end

endmodule

/* rtl/db_atr_execute.sv */
// ATR state machine, gpio output select, led map, ddr and misc output registers
`timescale 1ns/1ps

module db_atr_execute (
   input  logic                radio_clk,
   input  logic                i_arst_n,
   input  db_pkg::chan_flags_t i_rx_running,   // per channel
   input  db_pkg::chan_flags_t i_tx_running,
   db_regs_if.reader           regs,
   output db_pkg::atr_state_t  o_atr_state,
   output db_pkg::set_data_t   o_gpio_out,
   output db_pkg::set_data_t   o_gpio_ddr,
   output db_pkg::set_data_t   o_misc_out,
   output db_pkg::led_t        o_led
);
   import db_pkg::*;

   logic       rx_any;
   logic       tx_any;
   atr_state_t state_d;
   atr_state_t state_q;
   set_data_t  gpio_sel;   // ATR word for the current state
   led_t       led_d;

   // slot-level view needs only one active channel
   assign rx_any = |i_rx_running;
   assign tx_any = |i_tx_running;

   // ----------------------------------------
   // state
   // ----------------------------------------
   always_comb begin
      case ({tx_any, rx_any})
         2'b01:   state_d = ATR_RX;
         2'b10:   state_d = ATR_TX;
         2'b11:   state_d = ATR_FDX;
         default: state_d = ATR_IDLE;
      endcase
   end

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) state_q <= ATR_IDLE;
      else           state_q <= state_d;   // follows flags one edge later
   end

   assign o_atr_state = state_q;

   // gpio word and led pattern per state
   always_comb begin
      case (state_q)
         ATR_RX: begin
            gpio_sel = regs.atr_rx;
            led_d    = 3'b001;   // txrx rx
         end
         ATR_TX: begin
            gpio_sel = regs.atr_tx;
            led_d    = 3'b010;   // txrx tx
         end
         ATR_FDX: begin
            gpio_sel = regs.atr_fdx;
            led_d    = 3'b110;   // tx on txrx and rx on rx port
         end
         default: begin
            gpio_sel = regs.atr_idle;
            led_d    = 3'b000;
         end
      endcase
   end

   // ----------------------------------------
   // pin drive
   // ----------------------------------------
   // second stage so pins settle 2 edges after a flag or register change
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;
         o_misc_out <= '0;
         o_led      <= '0;
      end else begin
         o_gpio_out <= gpio_sel;
         o_gpio_ddr <= regs.gpio_ddr;
         o_misc_out <= regs.misc_out;
         o_led      <= led_d;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   a_state_legal: assert property (
      @(posedge radio_clk) disable iff (!i_arst_n)
      state_q inside {ATR_IDLE, ATR_RX, ATR_TX, ATR_FDX}
   ) else $error("ATR state outside the four legal values");

   // no flag anywhere means idle and dark leds two edges on
   a_led_dark_idle: assert property (
      @(posedge radio_clk) disable iff (!i_arst_n)
      (!rx_any && !tx_any) |-> ##2 (o_led == '0)
   ) else $error("leds lit two cycles after all run flags were low");

endmodule

/* rtl/db_params.svh */
// settings and readback address map, bus widths, slot channel count
`ifndef DB_PARAMS_SVH
`define DB_PARAMS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define DB_ADDR_W      8     // settings and readback address
`define DB_DATA_W      32    // register and gpio word
`define DB_RB_W        64    // readback word, two registers side by side

`define DB_CHANNELS    2     // channels per slot

// ----------------------------------------
// settings register offsets from base
// ----------------------------------------
`define DB_SR_BASE     160
`define DB_SR_ATR_IDLE 0     // gpio word while idle
`define DB_SR_ATR_RX   1
`define DB_SR_ATR_TX   2
`define DB_SR_ATR_FDX  3     // full duplex
`define DB_SR_GPIO_DDR 4     // pin direction
`define DB_SR_MISC_OUT 5

// readback words
`define DB_RB_BASE     16
`define DB_RB_INPUTS   0     // {misc in, gpio in}
`define DB_RB_OUTPUTS  1     // {ddr, gpio out}
`define DB_RB_ATR_LO   2     // {rx, idle}
`define DB_RB_ATR_HI   3     // {fdx, tx}

`endif

/* rtl/db_pkg.sv */
// vector typedefs for bus words, run flags and leds, ATR state enum
`include "db_params.svh"

package db_pkg;

   // ----------------------------------------
   // bus words
   // ----------------------------------------
   typedef logic [`DB_ADDR_W-1:0]   set_addr_t;   // settings or readback address
   typedef logic [`DB_DATA_W-1:0]   set_data_t;   // one slot register or gpio word
   typedef logic [`DB_RB_W-1:0]     rb_data_t;    // two words, upper and lower

   // one run flag per channel of the slot
   typedef logic [`DB_CHANNELS-1:0] chan_flags_t;

   // bit order {rx port, txrx tx, txrx rx}
   typedef logic [2:0]              led_t;

   // ----------------------------------------
   // ATR state
   // ----------------------------------------
   // encoding follows {tx, rx} of the or-ed run flags
   typedef enum logic [1:0] {
      ATR_IDLE = 2'b00,
      ATR_RX   = 2'b01,
      ATR_TX   = 2'b10,
      ATR_FDX  = 2'b11   // both directions active
   } atr_state_t;

endpackage

/* rtl/db_readback.sv */
// input capture registers and readback address mux
`timescale 1ns/1ps
`include "db_params.svh"

module db_readback (
   input  logic              radio_clk,
   input  logic              i_arst_n,
   input  logic              i_rb_stb,     // address sampled on this edge
   input  db_pkg::set_addr_t i_rb_addr,
   input  db_pkg::set_data_t i_gpio_in,    // daughterboard pins
   input  db_pkg::set_data_t i_misc_in,
   input  db_pkg::set_data_t i_gpio_out,   // word on the pins now
   db_regs_if.reader         regs,
   output logic              o_rb_valid,
   output db_pkg::rb_data_t  o_rb_data
);
   import db_pkg::*;

   // ----------------------------------------
   // absolute readback addresses
   // ----------------------------------------
   localparam set_addr_t ADDR_INPUTS  = set_addr_t'(`DB_RB_BASE + `DB_RB_INPUTS);
   localparam set_addr_t ADDR_OUTPUTS = set_addr_t'(`DB_RB_BASE + `DB_RB_OUTPUTS);
   localparam set_addr_t ADDR_ATR_LO  = set_addr_t'(`DB_RB_BASE + `DB_RB_ATR_LO);
   localparam set_addr_t ADDR_ATR_HI  = set_addr_t'(`DB_RB_BASE + `DB_RB_ATR_HI);

   set_data_t gpio_in_q;
   set_data_t misc_in_q;
   rb_data_t  rb_mux;

   // pins come from outside and register once before the mux
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         gpio_in_q <= '0;
         misc_in_q <= '0;
      end else begin
         gpio_in_q <= i_gpio_in;
         misc_in_q <= i_misc_in;
      end
   end

   // word select with the upper half first
   always_comb begin
      case (i_rb_addr)
         ADDR_INPUTS:  rb_mux = {misc_in_q, gpio_in_q};
         ADDR_OUTPUTS: rb_mux = {regs.gpio_ddr, i_gpio_out};
         ADDR_ATR_LO:  rb_mux = {regs.atr_rx, regs.atr_idle};
         ADDR_ATR_HI:  rb_mux = {regs.atr_fdx, regs.atr_tx};
         default:      rb_mux = '0;   // unmapped reads as zero
      endcase
   end

   // ----------------------------------------
   // response
   // ----------------------------------------
   // valid for one cycle per strobe and data held until the next one
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rb_valid <= 1'b0;
         o_rb_data  <= '0;
      end else begin
         o_rb_valid <= i_rb_stb;
         if (i_rb_stb) o_rb_data <= rb_mux;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   a_valid_after_stb: assert property (
      @(posedge radio_clk) disable iff (!i_arst_n)
      o_rb_valid |-> $past(i_rb_stb)
   ) else $error("readback valid without a strobe the cycle before");

endmodule

/* rtl/db_regs_if.sv */
// slot register bundle from settings decode to ATR execute and readback
`timescale 1ns/1ps

interface db_regs_if;
   import db_pkg::*;

   // gpio output word for each ATR state
   set_data_t atr_idle;
   set_data_t atr_rx;
   set_data_t atr_tx;
   set_data_t atr_fdx;

   set_data_t gpio_ddr;   // 1 drives the pin
   set_data_t misc_out;   // free-form slot outputs

   // decode side owns the registers
   modport writer (
      output atr_idle, atr_rx, atr_tx, atr_fdx,
      output gpio_ddr, misc_out
   );

   // execute and readback only look
   modport reader (
      input  atr_idle, atr_rx, atr_tx, atr_fdx,
      input  gpio_ddr, misc_out
   );

endinterface

/* rtl/db_settings_decode.sv */
// settings bus decode and the six slot registers
`timescale 1ns/1ps
`include "db_params.svh"

module db_settings_decode (
   input  logic              radio_clk,
   input  logic              i_arst_n,
   input  logic              i_set_stb,    // one write per high edge
   input  db_pkg::set_addr_t i_set_addr,
   input  db_pkg::set_data_t i_set_data,
   db_regs_if.writer         regs
);
   import db_pkg::*;

   // ----------------------------------------
   // absolute register addresses
   // ----------------------------------------
   localparam set_addr_t ADDR_ATR_IDLE = set_addr_t'(`DB_SR_BASE + `DB_SR_ATR_IDLE);
   localparam set_addr_t ADDR_ATR_RX   = set_addr_t'(`DB_SR_BASE + `DB_SR_ATR_RX);
   localparam set_addr_t ADDR_ATR_TX   = set_addr_t'(`DB_SR_BASE + `DB_SR_ATR_TX);
   localparam set_addr_t ADDR_ATR_FDX  = set_addr_t'(`DB_SR_BASE + `DB_SR_ATR_FDX);
   localparam set_addr_t ADDR_GPIO_DDR = set_addr_t'(`DB_SR_BASE + `DB_SR_GPIO_DDR);
   localparam set_addr_t ADDR_MISC_OUT = set_addr_t'(`DB_SR_BASE + `DB_SR_MISC_OUT);

   logic [5:0] wr_en;   // one-hot, bit index = register offset

   // address match
   always_comb begin
      wr_en = '0;
      if (i_set_stb) begin
         case (i_set_addr)
            ADDR_ATR_IDLE: wr_en[`DB_SR_ATR_IDLE] = 1'b1;
            ADDR_ATR_RX:   wr_en[`DB_SR_ATR_RX]   = 1'b1;
            ADDR_ATR_TX:   wr_en[`DB_SR_ATR_TX]   = 1'b1;
            ADDR_ATR_FDX:  wr_en[`DB_SR_ATR_FDX]  = 1'b1;
            ADDR_GPIO_DDR: wr_en[`DB_SR_GPIO_DDR] = 1'b1;
            ADDR_MISC_OUT: wr_en[`DB_SR_MISC_OUT] = 1'b1;
            default:       wr_en = '0;   // other slot or other block, ignore
         endcase
      end
   end

   // ----------------------------------------
   // register file
   // ----------------------------------------
   // loads on the strobe edge itself
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         regs.atr_idle <= '0;
         regs.atr_rx   <= '0;
         regs.atr_tx   <= '0;
         regs.atr_fdx  <= '0;
         regs.gpio_ddr <= '0;   // all pins input out of reset
         regs.misc_out <= '0;
      end else begin
         if (wr_en[`DB_SR_ATR_IDLE]) regs.atr_idle <= i_set_data;
         if (wr_en[`DB_SR_ATR_RX])   regs.atr_rx   <= i_set_data;
         if (wr_en[`DB_SR_ATR_TX])   regs.atr_tx   <= i_set_data;
         if (wr_en[`DB_SR_ATR_FDX])  regs.atr_fdx  <= i_set_data;
         if (wr_en[`DB_SR_GPIO_DDR]) regs.gpio_ddr <= i_set_data;
         if (wr_en[`DB_SR_MISC_OUT]) regs.misc_out <= i_set_data;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // an X address would silently drop or misroute a write
   a_set_addr_known: assert property (
      @(posedge radio_clk) disable iff (!i_arst_n)
      i_set_stb |-> !$isunknown(i_set_addr)
   ) else $error("settings strobe with unknown address");

endmodule

/* rtl/radio_db_core.sv */
// daughterboard slot controller top with settings decode, ATR execute, readback
`timescale 1ns/1ps

module radio_db_core (
   input  logic                radio_clk,
   input  logic                i_arst_n,

   // settings bus
   input  logic                i_set_stb,
   input  db_pkg::set_addr_t   i_set_addr,
   input  db_pkg::set_data_t   i_set_data,

   // readback bus
   input  logic                i_rb_stb,
   input  db_pkg::set_addr_t   i_rb_addr,
   output logic                o_rb_valid,
   output db_pkg::rb_data_t    o_rb_data,

   // channel run flags
   input  db_pkg::chan_flags_t i_rx_running,
   input  db_pkg::chan_flags_t i_tx_running,

   // daughterboard pins
   input  db_pkg::set_data_t   i_db_gpio_in,
   output db_pkg::set_data_t   o_db_gpio_out,
   output db_pkg::set_data_t   o_db_gpio_ddr,
   output db_pkg::led_t        o_radio_led,   // {rx, txrx tx, txrx rx}
   input  db_pkg::set_data_t   i_misc_in,
   output db_pkg::set_data_t   o_misc_out
);

   // ----------------------------------------
   // slot registers
   // ----------------------------------------
   db_regs_if regs ();

   // decode
   db_settings_decode u_decode (
      .radio_clk  (radio_clk),
      .i_arst_n   (i_arst_n),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .regs       (regs.writer)
   );

   // ----------------------------------------
   // ATR and pin drive
   // ----------------------------------------
   db_atr_execute u_execute (
      .radio_clk    (radio_clk),
      .i_arst_n     (i_arst_n),
      .i_rx_running (i_rx_running),
      .i_tx_running (i_tx_running),
      .regs         (regs.reader),
      .o_atr_state  (),                // state stays inside the slot
      .o_gpio_out   (o_db_gpio_out),
      .o_gpio_ddr   (o_db_gpio_ddr),
      .o_misc_out   (o_misc_out),
      .o_led        (o_radio_led)
   );

   // readback, sees the driven gpio word
   db_readback u_readback (
      .radio_clk  (radio_clk),
      .i_arst_n   (i_arst_n),
      .i_rb_stb   (i_rb_stb),
      .i_rb_addr  (i_rb_addr),
      .i_gpio_in  (i_db_gpio_in),
      .i_misc_in  (i_misc_in),
      .i_gpio_out (o_db_gpio_out),
      .regs       (regs.reader),
      .o_rb_valid (o_rb_valid),
      .o_rb_data  (o_rb_data)
   );

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -f tb.f --top-module radio_db_core_tb \
   -Mdir obj_dir -o radio_db_core_sim > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/radio_db_core_sim > sim.log 2>&1 \
   || echo "simulator exited with an error status"
grep -qx "No errors" sim.log \
   && echo "PASS" \
   || { echo "FAIL, see sim.log"; exit 1; }

/* tb.f */
+incdir+rtl
rtl/db_pkg.sv
rtl/db_regs_if.sv
rtl/db_settings_decode.sv
rtl/db_atr_execute.sv
rtl/db_readback.sv
rtl/radio_db_core.sv
dv/radio_db_core_tb.sv
